/* rtl/cpuPkg.sv */
/*
  CPU shared package for the memory and write-back back end:
  word widths, write-back control and the pipeline bundles
*/
package cpuPkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////
  localparam int dataWidth    = 16;  // Machine word
  localparam int regAddrWidth = 4;   // Register number

  typedef logic [dataWidth-1:0]    dataWord_t;  // Data or address word
  typedef logic [regAddrWidth-1:0] regAddr_t;   // Register number

  ////////////////////////////////////////
  // Write-back control, 8 bits
  ////////////////////////////////////////
  // Field order is destReg[7:4], regWrite[3], memToReg[2], pcToReg[1], halt[0]
  typedef struct packed {
    regAddr_t destReg;   // Destination register
    logic     regWrite;  // Write the register file
    logic     memToReg;  // Take load data
    logic     pcToReg;   // Link write, takes next PC
    logic     halt;      // Stop the machine
  } wbCtrl_t;

  // EX/MEM bundle, 58 bits
  typedef struct packed {
    dataWord_t pcNext;     // Next PC, used for link writes
    dataWord_t aluOut;     // ALU result, also memory address
    dataWord_t storeData;  // Store data
    logic      memRead;    // Load
    logic      memWrite;   // Store
    wbCtrl_t   wbCtrl;
  } exMemBundle_t;

  // MEM/WB bundle, 56 bits
  typedef struct packed {
    dataWord_t pcNext;
    dataWord_t aluOut;
    dataWord_t memData;  // Load data from memory stage
    wbCtrl_t   wbCtrl;
  } memWbBundle_t;

  // Bypass toward execute, 21 bits
  typedef struct packed {
    logic      valid;    // A register write is happening
    regAddr_t  destReg;
    dataWord_t value;
  } wbForward_t;

endpackage

/* rtl/dataMemory.sv */
/*
  Data memory, word addressed
  Combinational read while memRead is high, write on the clock edge
*/
module dataMemory #(
  parameter int memDepth = 256  // Words
) (
  input  logic               clk,
  input  cpuPkg::dataWord_t  addr,      // Word address
  input  cpuPkg::dataWord_t  wrData,    // Store data
  input  logic               memRead,   // Load strobe
  input  logic               memWrite,  // Store strobe
  output cpuPkg::dataWord_t  rdData     // Load data, zero when idle
);

  import cpuPkg::*;

  // Index width from depth, at least one bit
  localparam int idxWidth = (memDepth > 1) ? $clog2(memDepth) : 1;

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////
  dataWord_t mem [memDepth];  // No reset on contents

  logic [idxWidth-1:0] idx;  // Low address bits

  assign idx = addr[idxWidth-1:0];

  // Store lands at the edge ending the cycle
  always_ff @(posedge clk) begin
    if (memWrite) begin
      mem[idx] <= wrData;
    end
  end

  // Same-cycle read, quiet bus when not loading
  assign rdData = memRead ? mem[idx] : '0;

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  // Load and store come from one instruction, never both
  rdWrExclusive: assert property (
    @(posedge clk) !(memRead && memWrite)
  ) else $error("dataMemory: memRead and memWrite both high");

  // Address must land inside the array, no aliasing through the low bits
  addrInRange: assert property (
    @(posedge clk) (memRead || memWrite) |-> (addr < memDepth)
  ) else $error("dataMemory: address %0h beyond depth %0d", addr, memDepth);

endmodule

/* rtl/memWbPipeReg.sv */
/*
  MEM/WB pipeline register
  Reset clears all fields and flush clears all but the next PC
*/
module memWbPipeReg (
  input  logic                  clk,
  input  logic                  rst,      // Synchronous active-high reset
  input  logic                  flush,    // Empty this slot
  input  cpuPkg::exMemBundle_t  exMem,    // From memory stage inputs
  input  cpuPkg::dataWord_t     memData,  // Same-cycle load data
  output cpuPkg::memWbBundle_t  memWb     // To write-back
);

  import cpuPkg::*;

  logic clr;  // Reset or flush

  assign clr = rst | flush;

  ////////////////////////////////////////
  // Next PC cleared by reset only
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      memWb.pcNext <= '0;
    end else begin
      memWb.pcNext <= exMem.pcNext;  // Survives a flush
    end
  end

  ////////////////////////////////////////
  // Results and control cleared by reset or flush
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (clr) begin
      memWb.aluOut  <= '0;
      memWb.memData <= '0;
      memWb.wbCtrl  <= '0;  // Bubble that writes nothing
    end else begin
      memWb.aluOut  <= exMem.aluOut;
      memWb.memData <= memData;
      memWb.wbCtrl  <= exMem.wbCtrl;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  // Flushed slot must carry no write-back action
  flushKillsCtrl: assert property (
    @(posedge clk) flush |=> (memWb.wbCtrl == '0)
  ) else $error("memWbPipeReg: wbCtrl not cleared after flush");

endmodule

/* rtl/writeBackStage.sv */
/*
  Write-back stage: picks link, load or ALU result,
  drives the register write port, forwarding and a sticky halt
*/
module writeBackStage (
  input  logic                  clk,
  input  logic                  rst,
  input  cpuPkg::memWbBundle_t  memWb,    // From MEM/WB register
  output logic                  wrEn,     // Register write enable
  output cpuPkg::regAddr_t      wrAddr,
  output cpuPkg::dataWord_t     wrData,
  output cpuPkg::wbForward_t    forward,  // Bypass toward execute
  output logic                  halted    // Sticky until reset
);

  import cpuPkg::*;

  wbCtrl_t ctrl;

  assign ctrl = memWb.wbCtrl;

  ////////////////////////////////////////
  // Result select
  ////////////////////////////////////////
  always_comb begin
    if (ctrl.pcToReg) begin
      wrData = memWb.pcNext;   // Link write wins
    end else if (ctrl.memToReg) begin
      wrData = memWb.memData;  // Load
    end else begin
      wrData = memWb.aluOut;   // Default
    end
  end

  // Register 0 is hardwired, so never claim a write to it
  assign wrEn   = ctrl.regWrite && (ctrl.destReg != '0);
  assign wrAddr = ctrl.destReg;

  assign forward.valid   = wrEn;
  assign forward.destReg = wrAddr;
  assign forward.value   = wrData;

  ////////////////////////////////////////
  // Halt latch
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      halted <= 1'b0;
    end else if (ctrl.halt) begin
      halted <= 1'b1;  // Only reset clears
    end
  end

  // Decode gives one source at most
  oneSource: assert property (
    @(posedge clk) disable iff (rst) !(ctrl.pcToReg && ctrl.memToReg)
  ) else $error("writeBackStage: pcToReg and memToReg both set");

endmodule

/* rtl/regFile.sv */
/*
  Register file, one write port and two combinational read ports
  Register 0 reads zero and reads bypass a same-cycle write
*/
module regFile #(
  parameter int numRegs = 16
) (
  input  logic               clk,
  input  logic               rst,      // Clears every register
  input  logic               wrEn,
  input  cpuPkg::regAddr_t   wrAddr,
  input  cpuPkg::dataWord_t  wrData,
  input  cpuPkg::regAddr_t   rdAddrA,
  input  cpuPkg::regAddr_t   rdAddrB,
  output cpuPkg::dataWord_t  rdDataA,
  output cpuPkg::dataWord_t  rdDataB
);

  import cpuPkg::*;

  dataWord_t regs [numRegs];

  ////////////////////////////////////////
  // Write port
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (wrAddr != '0)) begin
      regs[wrAddr] <= wrData;  // Register 0 left alone
    end
  end

  ////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////
  // Write-first bypass lets a read of the register being written see the new value
  function automatic dataWord_t readPort(input regAddr_t addr);
    dataWord_t val;
    if (addr == '0) begin
      val = '0;              // Hardwired zero
    end else if (wrEn && (wrAddr == addr)) begin
      val = wrData;          // Bypass
    end else begin
      val = regs[addr];
    end
    return val;
  endfunction

  always_comb begin
    rdDataA = readPort(rdAddrA);
    rdDataB = readPort(rdAddrB);
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  // Write-back must only target registers that exist
  wrInRange: assert property (
    @(posedge clk) disable iff (rst) wrEn |-> (wrAddr < numRegs)
  ) else $error("regFile: write to register %0d of %0d", wrAddr, numRegs);

endmodule

/* rtl/memWbSubsystem.sv */
/*
  CPU back end: data memory, MEM/WB register,
  write-back stage and register file
*/
module memWbSubsystem #(
  parameter int memDepth = 256,  // Data memory words
  parameter int numRegs  = 16    // Architectural registers
) (
  input  logic                  clk,
  input  logic                  rst,      // Sync, active high
  input  logic                  flush,    // Kill the slot entering MEM/WB
  input  cpuPkg::exMemBundle_t  exMem,    // From execute
  input  cpuPkg::regAddr_t      rdAddrA,
  input  cpuPkg::regAddr_t      rdAddrB,
  output cpuPkg::dataWord_t     rdDataA,
  output cpuPkg::dataWord_t     rdDataB,
  output cpuPkg::wbForward_t    forward,  // Bypass toward execute
  output logic                  halted
);

  import cpuPkg::*;

  ////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////
  dataWord_t    memData;  // Same-cycle load data
  memWbBundle_t memWb;    // Pipeline register output
  logic         wrEn;
  regAddr_t     wrAddr;
  dataWord_t    wrData;

  // Memory stage, ALU result is the address, flush not seen here
  dataMemory #(
    .memDepth (memDepth)
  ) uDataMemory (
    .clk      (clk),
    .addr     (exMem.aluOut),
    .wrData   (exMem.storeData),
    .memRead  (exMem.memRead),
    .memWrite (exMem.memWrite),
    .rdData   (memData)
  );

  memWbPipeReg uMemWbPipeReg (
    .clk     (clk),
    .rst     (rst),
    .flush   (flush),
    .exMem   (exMem),
    .memData (memData),
    .memWb   (memWb)
  );

  writeBackStage uWriteBackStage (
    .clk     (clk),
    .rst     (rst),
    .memWb   (memWb),
    .wrEn    (wrEn),
    .wrAddr  (wrAddr),
    .wrData  (wrData),
    .forward (forward),
    .halted  (halted)
  );

  // Register update lands one edge after MEM/WB, two after exMem
  regFile #(
    .numRegs (numRegs)
  ) uRegFile (
    .clk     (clk),
    .rst     (rst),
    .wrEn    (wrEn),
    .wrAddr  (wrAddr),
    .wrData  (wrData),
    .rdAddrA (rdAddrA),
    .rdAddrB (rdAddrB),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB)
  );

endmodule

/* tests/tb_memWbSubsystem.sv */
/*
  Testbench for the CPU back end that replays the stimulus file and checks
  register reads, forwarding and halt against a reference model
*/
module tb_memWbSubsystem;

  timeunit 1ns;
  timeprecision 100ps;

  import cpuPkg::*;

  localparam int    memDepth  = 256;
  localparam int    numRegs   = 16;
  localparam int    clkPeriod = 40;                     // ns
  localparam string stimPath  = "tests/memWbStim.txt";

  logic         clk = 1'b0;
  logic         rst;
  logic         flush;
  exMemBundle_t exMem;
  regAddr_t     rdAddrA;
  regAddr_t     rdAddrB;
  dataWord_t    rdDataA;
  dataWord_t    rdDataB;
  wbForward_t   forward;
  logic         halted;

  memWbSubsystem #(
    .memDepth (memDepth),
    .numRegs  (numRegs)
  ) memWbSubsystem_inst (
    .clk     (clk),
    .rst     (rst),
    .flush   (flush),
    .exMem   (exMem),
    .rdAddrA (rdAddrA),
    .rdAddrB (rdAddrB),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB),
    .forward (forward),
    .halted  (halted)
  );

  always #(clkPeriod / 2) clk = ~clk;

  ////////////////////////////////////////
  // Reference model state
  ////////////////////////////////////////
  dataWord_t mdlMem [memDepth];
  dataWord_t mdlRegs [numRegs];
  logic      pendWrite = 1'b0;  // Slot in write-back will write
  regAddr_t  pendReg   = '0;
  dataWord_t pendVal   = '0;
  logic      pendHalt  = 1'b0;
  logic      mdlHalted = 1'b0;

  string       stimLines [$];      // Command lines without comments
  longint      watchNs  = 0;       // Watchdog budget that stays zero until known
  logic [31:0] rngState = 32'd69898;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  ////////////////////////////////////////
  // Failure reporting and compares
  ////////////////////////////////////////
  task automatic failNow();
    $display("Regression failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic badLine(input string line);
    $display("Malformed stimulus line: %s", line);
    failNow();
  endtask

  task automatic checkWord(input string name, input dataWord_t expVal, input dataWord_t actVal);
    if (actVal !== expVal) begin
      $display("ERR t=%0d ns %s expected %h actual %h", $time, name, expVal, actVal);
      failNow();
    end
  endtask

  task automatic checkForward(input string name, input wbForward_t expVal,
                              input wbForward_t actVal);
    logic bad;
    bad = (actVal.valid !== expVal.valid);
    if (expVal.valid) begin
      bad = bad || (actVal !== expVal);  // Register and value only count when valid
    end
    if (bad) begin
      $display("ERR t=%0d ns %s expected %h actual %h", $time, name, expVal, actVal);
      failNow();
    end
  endtask

  task automatic checkBit(input string name, input logic expVal, input logic actVal);
    if (actVal !== expVal) begin
      $display("ERR t=%0d ns %s expected %b actual %b", $time, name, expVal, actVal);
      failNow();
    end
  endtask

  // File expectation against the model
  task automatic crossCheck(input string what, input int fileVal, input int mdlVal);
    if (fileVal != mdlVal) begin
      $display("Stimulus file expects %h for %s but the reference model gives %h",
               fileVal, what, mdlVal);
      failNow();
    end
  endtask

  ////////////////////////////////////////
  // Model of one clock edge
  ////////////////////////////////////////
  task automatic modelEdge(input exMemBundle_t b, input logic fl, input logic r);
    dataWord_t ld;
    ld = b.memRead ? mdlMem[b.aluOut[7:0]] : '0;  // Read sees memory before the store
    if (b.memWrite) begin
      mdlMem[b.aluOut[7:0]] = b.storeData;  // Memory ignores reset and flush
    end
    if (r) begin
      foreach (mdlRegs[i]) begin
        mdlRegs[i] = '0;
      end
      pendWrite = 1'b0;
      pendHalt  = 1'b0;
      mdlHalted = 1'b0;
    end else begin
      if (pendWrite) begin
        mdlRegs[pendReg] = pendVal;  // Retire write-back slot
      end
      if (pendHalt) begin
        mdlHalted = 1'b1;
      end
      if (fl) begin
        pendWrite = 1'b0;  // Bubble
        pendHalt  = 1'b0;
      end else begin
        pendWrite = b.wbCtrl.regWrite && (b.wbCtrl.destReg != 0);
        pendReg   = b.wbCtrl.destReg;
        pendVal   = b.wbCtrl.pcToReg ? b.pcNext : (b.wbCtrl.memToReg ? ld : b.aluOut);
        pendHalt  = b.wbCtrl.halt;
      end
    end
  endtask

  // Write-first read with r0 hardwired
  function automatic dataWord_t expectRead(input regAddr_t r);
    if (r == 0) return '0;
    if (pendWrite && (pendReg == r)) return pendVal;
    return mdlRegs[r];
  endfunction

  ////////////////////////////////////////
  // Drive helpers
  ////////////////////////////////////////
  task automatic stepCycle();
    modelEdge(exMem, flush, rst);
    @(posedge clk);
    @(negedge clk);  // Back on the falling edge
  endtask

  // Random bundle that writes nothing and never halts
  task automatic driveIdle();
    exMemBundle_t b;
    logic [31:0]  r;
    rngState = xorshift32(rngState);
    r = rngState;
    b = '0;
    b.pcNext          = r[15:0];
    b.storeData       = r[31:16];
    b.aluOut          = {8'h00, r[23:16]};  // Stays inside memory
    b.memRead         = r[0];
    b.wbCtrl.memToReg = r[1];
    b.wbCtrl.destReg  = r[7:4];
    exMem = b;
    flush = r[2];
  endtask

  ////////////////////////////////////////
  // Stimulus file
  ////////////////////////////////////////
  task automatic loadStim(output int cycles);
    int    fd;
    int    n;
    int    cnt;
    string line;
    string word;
    cycles = 0;
    fd = $fopen(stimPath, "r");
    if (fd == 0) begin
      $display("Cannot open stimulus file %s", stimPath);
      failNow();
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if ((n > 0) && (line.len() > 0) && (line.getc(0) != "#") && (line.getc(0) != "\n")
          && (line.getc(0) != "\r") && (line.getc(0) != " ")) begin
        stimLines.push_back(line);
        if ((line.getc(0) == "I") || (line.getc(0) == "R")) begin
          cycles += 1;
        end else if ((line.getc(0) == "N") || (line.getc(0) == "T")) begin
          if ($sscanf(line, "%s %d", word, cnt) != 2) badLine(line);
          cycles += cnt;
        end
      end
    end
    $fclose(fd);
    if (stimLines.size() == 0) begin
      $display("Stimulus file %s holds no commands", stimPath);
      failNow();
    end
  endtask

  task automatic runLine(input string line);
    int           pcN, alu, sd, mr, mw, dr, rw, m2r, p2r, hl, fl;
    int           a, e, v;
    exMemBundle_t b;
    wbForward_t   f;
    case (line.getc(0))
      "I": begin
        if ($sscanf(line, "I %h %h %h %h %h %h %h %h %h %h %h",
                    pcN, alu, sd, mr, mw, dr, rw, m2r, p2r, hl, fl) != 11) badLine(line);
        b.pcNext    = pcN[15:0];
        b.aluOut    = alu[15:0];
        b.storeData = sd[15:0];
        b.memRead   = mr[0];
        b.memWrite  = mw[0];
        b.wbCtrl    = '{destReg: dr[3:0], regWrite: rw[0], memToReg: m2r[0],
                        pcToReg: p2r[0], halt: hl[0]};
        exMem = b;
        flush = fl[0];
        stepCycle();
        driveIdle();
      end
      "R": begin
        if ($sscanf(line, "R %h %h", a, e) != 2) badLine(line);
        rdAddrA = a[3:0];
        rdAddrB = ~a[3:0];  // Port B reads the mirror register
        #(clkPeriod / 4);  // Read ports settle
        crossCheck("register read", e, int'(expectRead(a[3:0])));
        checkWord("rdDataA", e[15:0], rdDataA);
        checkWord("rdDataB", expectRead(~a[3:0]), rdDataB);
        stepCycle();
        driveIdle();
      end
      "F": begin
        if ($sscanf(line, "F %h %h %h", v, a, e) != 3) badLine(line);
        f = '{valid: v[0], destReg: a[3:0], value: e[15:0]};
        crossCheck("forward.valid", v, int'(pendWrite));
        if (f.valid) begin
          crossCheck("forward.destReg", a, int'(pendReg));
          crossCheck("forward.value", e, int'(pendVal));
        end
        checkForward("forward", f, forward);
      end
      "H": begin
        if ($sscanf(line, "H %h", v) != 1) badLine(line);
        crossCheck("halted", v, int'(mdlHalted));
        checkBit("halted", v[0], halted);
      end
      "N": begin
        if ($sscanf(line, "N %d", a) != 1) badLine(line);
        repeat (a) begin
          stepCycle();
          driveIdle();
        end
      end
      "T": begin
        if ($sscanf(line, "T %d", a) != 1) badLine(line);
        rst = 1'b1;
        repeat (a) begin
          stepCycle();
          driveIdle();
        end
        rst = 1'b0;
      end
      default: badLine(line);  // Unknown command letter
    endcase
  endtask

  ////////////////////////////////////////
  // Watchdog and main sequence
  ////////////////////////////////////////
  initial begin
    wait (watchNs != 0);
    #(watchNs);
    $display("Watchdog expired after %0d ns without reaching the end of the stimulus", watchNs);
    failNow();
  end

  initial begin
    int cycles;
    rst     = 1'b1;
    flush   = 1'b0;
    exMem   = '0;
    rdAddrA = '0;
    rdAddrB = '0;
    loadStim(cycles);
    watchNs = longint'(cycles + 4 + 50) * clkPeriod;  // Reset plus margin
    repeat (4) stepCycle();
    rst = 1'b0;
    driveIdle();
    foreach (stimLines[i]) begin
      runLine(stimLines[i]);
    end
    $display("Regression passed");
    $finish;
  end

endmodule

/* tests/memWbStim.txt */
# Numbers hex, N and T counts decimal. I pcNext aluOut storeData memRead memWrite
# destReg regWrite memToReg pcToReg halt flush | R reg value | F valid reg value | H bit
# Reset state
R 1 0000
R 7 0000
R f 0000
F 0 0 0000
H 0
# ALU result into r3, forwarded one cycle after issue
I 0010 1234 0000 0 0 3 1 0 0 0 0
F 1 3 1234
R 3 1234
R 3 1234
# Back-to-back ALU writes
I 0012 0101 0000 0 0 1 1 0 0 0 0
I 0014 0202 0000 0 0 2 1 0 0 0 0
F 1 2 0202
R 1 0101
R 2 0202
# Store then load into r5
I 0016 0020 beef 0 1 0 0 0 0 0 0
F 0 0 0000
I 0018 0020 0000 1 0 5 1 1 0 0 0
F 1 5 beef
N 2
R 5 beef
# Link write of next PC into r10
I 0042 0099 0000 0 0 a 1 0 1 0 0
F 1 a 0042
R a 0042
# Flushed write leaves r3, store under flush still lands
I 0050 1111 0000 0 0 3 1 0 0 0 1
F 0 0 0000
R 3 1234
I 0052 0030 cafe 0 1 0 0 0 0 0 1
I 0054 0030 0000 1 0 6 1 1 0 0 0
F 1 6 cafe
R 6 cafe
# Write to r0 dropped
I 0060 5555 0000 0 0 0 1 0 0 0 0
F 0 0 0000
R 0 0000
# Sticky halt
I 0070 0000 0000 0 0 0 0 0 0 1 0
H 0
N 1
H 1
N 6
H 1
R 3 1234
# Reset clears registers and halt
T 4
R 3 0000
R a 0000
H 0
F 0 0 0000
# Flushed halt never latches
I 0080 0000 0000 0 0 0 0 0 0 1 1
I 0082 4444 0000 0 0 4 1 0 0 0 0
N 2
H 0
R 4 4444

/* sim.f */
rtl/cpuPkg.sv
rtl/dataMemory.sv
rtl/memWbPipeReg.sv
rtl/writeBackStage.sv
rtl/regFile.sv
rtl/memWbSubsystem.sv
tests/tb_memWbSubsystem.sv

/* runSim.sh */
#!/bin/sh
# Build the back end testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

top=tb_memWbSubsystem
log=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module "$top" -f sim.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/V$top > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Regression passed" "$log"; then
  exit 0
else
  echo "Pass line not found in $log"
  exit 1
fi
